// ==== include/rob_params.svh ====
// Reorder buffer sizing constants
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// Number of reorder slots
`define ROB_ENTRIES 8

// Width of a slot id, enough to index every slot
`define ROB_PTR_W 3

// Sequence number width, one bit wider than a slot id so it can hold
// an occupancy of zero up to a completely full buffer
`define ROB_SN_W 4

// Width of the instruction tag carried from dispatch to commit
`define ROB_TAG_W 8

// Depth of the commit output queue
`define ROB_OQ_DEPTH 2

`endif

// ==== rtl/rob_pkg.sv ====
// Reorder buffer types
`default_nettype none
`include "rob_params.svh"

package rob_pkg;

	// ==============================
	// Slot state
	// ==============================

	// One reorder slot, packed into a single word
	typedef struct packed {
		logic                  v;
		logic                  executed;
		logic                  is_branch;
		logic [`ROB_TAG_W-1:0] tag;
		logic [7:0]            result;
	} rob_entry_t;

	// ==============================
	// Port payloads
	// ==============================

	// Dispatch carries the tag and whether the instruction is a branch
	typedef struct packed {
		logic [`ROB_TAG_W-1:0] tag;
		logic                  is_branch;
	} rob_dispatch_t;

	// A completion names the slot and the value it produced
	typedef struct packed {
		logic [`ROB_PTR_W-1:0] id;
		logic [7:0]            result;
	} rob_complete_t;

	// A resolve names the branch slot and says whether it was mispredicted
	typedef struct packed {
		logic [`ROB_PTR_W-1:0] id;
		logic                  miss;
	} rob_resolve_t;

	// What leaves the buffer at commit
	typedef struct packed {
		logic [`ROB_TAG_W-1:0] tag;
		logic [7:0]            result;
	} rob_commit_t;

	// Branch recovery states
	typedef enum logic {
		REC_IDLE,
		REC_FLUSH
	} rob_rec_state_t;

endpackage

`default_nettype wire

// ==== rtl/rob_stomp.sv ====
// Branch miss stomp mask
`default_nettype none
`include "rob_params.svh"

module rob_stomp (
	input  wire rob_pkg::rob_entry_t [`ROB_ENTRIES-1:0]                reb,
	input  wire logic                                                  branchmiss,
	input  wire logic [`ROB_PTR_W-1:0]                                 missid,
	input  wire logic [`ROB_ENTRIES-1:0][`ROB_SN_W-1:0]                sns,
	output logic      [`ROB_ENTRIES-1:0]                               stomp
);

	localparam int N = `ROB_ENTRIES;

	// Sequence number of the mispredicted branch itself
	logic [`ROB_SN_W-1:0] miss_sn;

	assign miss_sn = sns[missid];

	// ==============================
	// Younger-than-branch compare
	// ==============================

	// Sequence numbers count up from the head, so a plain magnitude compare
	// tells which slots were dispatched after the branch
	// No wrap correction is needed because the head is always zero
	always_comb begin
		stomp = '0;
		for (int n = 0; n < N; n++) begin
			// Only occupied slots can be discarded
			if (branchmiss && reb[n].v) begin
				if (sns[n] > miss_sn)
					stomp[n] = 1'b1;
			end
		end
	end

	// Executed entries older than the branch are left alone
	// They drain through the normal commit path

endmodule

`default_nettype wire

// ==== rtl/rob_seq_alloc.sv ====
// Reorder buffer pointers and sequence numbers
`default_nettype none
`include "rob_params.svh"

module rob_seq_alloc (
	input  wire logic                                   clk,
	input  wire logic                                   rst_n,
	input  wire logic                                   alloc,
	input  wire logic                                   release_head,
	input  wire logic                                   rewind,
	input  wire logic [`ROB_PTR_W-1:0]                  missid,
	output logic      [`ROB_PTR_W-1:0]                  head,
	output logic      [`ROB_PTR_W-1:0]                  tail,
	output logic                                        full,
	output logic                                        empty,
	output logic      [`ROB_ENTRIES-1:0][`ROB_SN_W-1:0] sns
);

	localparam int N  = `ROB_ENTRIES;
	localparam int PW = `ROB_PTR_W;
	localparam int SW = `ROB_SN_W;

	// Number of occupied slots from zero up to N
	logic [SW-1:0] count;

	assign full  = (count == SW'(N));
	assign empty = (count == '0);

	// ==============================
	// Sequence numbers
	// ==============================

	// Each slot's age is its distance from the head
	// The head is always zero and the youngest entry is count - 1
	// The difference wraps at the slot count before it is widened
	always_comb begin
		for (int i = 0; i < N; i++)
			sns[i] = SW'({PW'(i) - head});
	end

	// ==============================
	// Pointer and count update
	// ==============================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			// The oldest entry leaves independently of any rewind
			if (release_head)
				head <= head + 1'b1;

			if (rewind) begin
				// Everything after the branch is gone, so the tail sits right behind it
				tail  <= missid + 1'b1;
				// Count keeps the branch and all older entries minus a head that leaves now
				count <= sns[missid] + 1'b1 - SW'(release_head);
			end else begin
				if (alloc)
					tail <= tail + 1'b1;
				case ({alloc, release_head})
					2'b10:   count <= count + 1'b1;
					2'b01:   count <= count - 1'b1;
					default: count <= count;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/rob_entries.sv ====
// Reorder buffer entry storage
`default_nettype none
`include "rob_params.svh"

module rob_entries (
	input  wire logic                                  clk,
	input  wire logic                                  rst_n,
	input  wire logic                                  alloc,
	input  wire logic [`ROB_PTR_W-1:0]                 alloc_id,
	input  wire rob_pkg::rob_dispatch_t                disp,
	input  wire logic                                  cmpl_valid,
	input  wire rob_pkg::rob_complete_t                cmpl,
	input  wire logic                                  res_valid,
	input  wire rob_pkg::rob_resolve_t                 res,
	input  wire logic [`ROB_ENTRIES-1:0]               stomp,
	input  wire logic [`ROB_PTR_W-1:0]                 head,
	input  wire logic                                  oq_ready,
	output rob_pkg::rob_entry_t [`ROB_ENTRIES-1:0]     reb,
	output logic                                       release_head,
	output rob_pkg::rob_commit_t                       head_rec
);

	import rob_pkg::*;

	localparam int N  = `ROB_ENTRIES;
	localparam int PW = `ROB_PTR_W;

	rob_entry_t [N-1:0] ent;
	rob_entry_t         head_ent;

	// Per-slot hits for completions and resolves that land on a live slot
	logic [N-1:0] cmpl_hit;
	logic [N-1:0] res_hit;

	assign reb = ent;

	// ==============================
	// Head release
	// ==============================

	assign head_ent     = ent[head];
	assign release_head = head_ent.v && head_ent.executed && oq_ready;
	assign head_rec     = '{tag: head_ent.tag, result: head_ent.result};

	// Events aimed at an empty slot fall through without effect
	always_comb begin
		for (int i = 0; i < N; i++) begin
			cmpl_hit[i] = cmpl_valid && (cmpl.id == PW'(i)) && ent[i].v;
			res_hit[i]  = res_valid && (res.id == PW'(i)) && ent[i].v;
		end
	end

	// ==============================
	// Slot update
	// ==============================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < N; i++) begin
				ent[i].v        <= 1'b0;
				ent[i].executed <= 1'b0;
			end
		end else begin
			for (int i = 0; i < N; i++) begin
				if (stomp[i]) begin
					// A discarded slot wins over anything else arriving for it
					ent[i].v        <= 1'b0;
					ent[i].executed <= 1'b0;
				end else if (release_head && (head == PW'(i))) begin
					ent[i].v        <= 1'b0;
					ent[i].executed <= 1'b0;
				end else if (cmpl_hit[i]) begin
					ent[i].executed <= 1'b1;
					ent[i].result   <= cmpl.result;
				end else if (res_hit[i]) begin
					// A resolved branch counts as done whether or not it missed
					ent[i].executed <= 1'b1;
				end
			end

			// New entries go to the tail, which is never a live slot here
			if (alloc) begin
				ent[alloc_id].v         <= 1'b1;
				ent[alloc_id].executed  <= 1'b0;
				ent[alloc_id].is_branch <= disp.is_branch;
				ent[alloc_id].tag       <= disp.tag;
				ent[alloc_id].result    <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/rob_recovery_fsm.sv ====
// Branch miss recovery FSM
`default_nettype none
`include "rob_params.svh"

module rob_recovery_fsm (
	input  wire logic                     clk,
	input  wire logic                     rst_n,
	input  wire logic                     res_valid,
	input  wire rob_pkg::rob_resolve_t    res,
	input  wire logic [`ROB_ENTRIES-1:0]  slot_valid,
	output logic                          miss_strobe,
	output logic      [`ROB_PTR_W-1:0]    missid,
	output logic                          flushing
);

	import rob_pkg::*;

	rob_rec_state_t state;

	// A new miss is taken only while fully idle
	logic accept;

	// The strobe cycle and the flush cycle both shut out a second miss
	// A miss on a slot that is already gone is dropped as well
	assign accept = (state == REC_IDLE) && !miss_strobe && res_valid && res.miss
		&& slot_valid[res.id];

	assign flushing = (state == REC_FLUSH);

	// ==============================
	// State and strobe
	// ==============================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state       <= REC_IDLE;
			miss_strobe <= 1'b0;
		end else begin
			// Stomp and rewind fire on the edge after the miss is sampled
			miss_strobe <= accept;
			case (state)
				REC_IDLE: begin
					// Flush starts once the strobe has been seen
					if (miss_strobe)
						state <= REC_FLUSH;
				end
				REC_FLUSH: begin
					state <= REC_IDLE;
				end
				default: state <= REC_IDLE;
			endcase
		end
	end

	// The branch slot is held for the stomp compare and the tail rewind
	always_ff @(posedge clk) begin
		if (accept)
			missid <= res.id;
	end

endmodule

`default_nettype wire

// ==== rtl/rob_out_queue.sv ====
// Commit output queue
`default_nettype none
`include "rob_params.svh"

module rob_out_queue #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = `ROB_OQ_DEPTH
) (
	input  wire logic     clk,
	input  wire logic     rst_n,
	input  wire logic     in_valid,
	output logic          in_ready,
	input  wire payload_t in_data,
	output logic          out_valid,
	input  wire logic     out_ready,
	output payload_t      out_data
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	payload_t       mem [DEPTH];
	logic [AW-1:0]  wr_ptr;
	logic [AW-1:0]  rd_ptr;
	logic [AW:0]    cnt;
	logic [AW:0]    cnt_next;
	logic           full;
	logic           push;
	logic           pop;

	function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
		return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// ==============================
	// Handshake
	// ==============================

	assign full = (cnt == (AW + 1)'(DEPTH));

	// A full queue still takes a record when the oldest one leaves this cycle
	assign in_ready = !full || out_ready;
	assign push     = in_valid && in_ready;
	assign pop      = out_valid && out_ready;
	assign out_data = mem[rd_ptr];

	always_comb begin
		cnt_next = cnt;
		if (push && !pop)
			cnt_next = cnt + 1'b1;
		else if (pop && !push)
			cnt_next = cnt - 1'b1;
	end

	// ==============================
	// Pointers and storage
	// ==============================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			cnt       <= '0;
			out_valid <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			cnt <= cnt_next;
			// Valid is kept in its own flop so the port sees no logic
			out_valid <= (cnt_next != '0);
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= in_data;
	end

endmodule

`default_nettype wire

// ==== rtl/rob_top.sv ====
// Reorder buffer top level
`default_nettype none
`include "rob_params.svh"

module rob_top (
	input  wire logic                   clk,
	input  wire logic                   rst_n,
	input  wire logic                   disp_valid,
	output logic                        disp_ready,
	input  wire rob_pkg::rob_dispatch_t disp,
	output logic [`ROB_PTR_W-1:0]       disp_id,
	input  wire logic                   cmpl_valid,
	input  wire rob_pkg::rob_complete_t cmpl,
	input  wire logic                   res_valid,
	input  wire rob_pkg::rob_resolve_t  res,
	output logic                        cmt_valid,
	input  wire logic                   cmt_ready,
	output rob_pkg::rob_commit_t        cmt
);

	import rob_pkg::*;

	localparam int N  = `ROB_ENTRIES;
	localparam int PW = `ROB_PTR_W;

	rob_entry_t [N-1:0]                reb;
	logic [N-1:0][`ROB_SN_W-1:0]       sns;
	logic [N-1:0]                      stomp;
	logic [N-1:0]                      slot_valid;
	logic [PW-1:0]                     head;
	logic [PW-1:0]                     tail;
	logic [PW-1:0]                     missid;
	logic                              full;
	logic                              alloc;
	logic                              release_head;
	logic                              miss_strobe;
	logic                              flushing;
	logic                              oq_ready;
	rob_commit_t                       head_rec;

	// ==============================
	// Dispatch accept
	// ==============================

	// Dispatch also waits out the strobe cycle so a new entry never races the rewind
	assign disp_ready = !full && !flushing && !miss_strobe;
	assign alloc      = disp_valid && disp_ready;
	assign disp_id    = tail;

	// A head that leaves this cycle can no longer take a miss
	always_comb begin
		for (int i = 0; i < N; i++)
			slot_valid[i] = reb[i].v && !(release_head && (head == PW'(i)));
	end

	rob_seq_alloc u_alloc (
		.clk          (clk),
		.rst_n        (rst_n),
		.alloc        (alloc),
		.release_head (release_head),
		.rewind       (miss_strobe),
		.missid       (missid),
		.head         (head),
		.tail         (tail),
		.full         (full),
		.empty        (),
		.sns          (sns)
	);

	rob_entries u_entries (
		.clk          (clk),
		.rst_n        (rst_n),
		.alloc        (alloc),
		.alloc_id     (tail),
		.disp         (disp),
		.cmpl_valid   (cmpl_valid),
		.cmpl         (cmpl),
		.res_valid    (res_valid),
		.res          (res),
		.stomp        (stomp),
		.head         (head),
		.oq_ready     (oq_ready),
		.reb          (reb),
		.release_head (release_head),
		.head_rec     (head_rec)
	);

	rob_stomp u_stomp (
		.reb        (reb),
		.branchmiss (miss_strobe),
		.missid     (missid),
		.sns        (sns),
		.stomp      (stomp)
	);

	rob_recovery_fsm u_rec (
		.clk         (clk),
		.rst_n       (rst_n),
		.res_valid   (res_valid),
		.res         (res),
		.slot_valid  (slot_valid),
		.miss_strobe (miss_strobe),
		.missid      (missid),
		.flushing    (flushing)
	);

	// Released heads are queued here so commit back-pressure never stalls a slot update
	rob_out_queue #(
		.payload_t (rob_commit_t)
	) u_oq (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (release_head),
		.in_ready  (oq_ready),
		.in_data   (head_rec),
		.out_valid (cmt_valid),
		.out_ready (cmt_ready),
		.out_data  (cmt)
	);

endmodule

`default_nettype wire

// ==== test/rob_sva.sv ====
// Reorder buffer assertions
`default_nettype none
`include "rob_params.svh"

module rob_sva (
	input wire logic                                   clk,
	input wire logic                                   rst_n,
	input wire logic                                   disp_ready,
	input wire logic                                   alloc,
	input wire logic [`ROB_PTR_W-1:0]                  tail,
	input wire rob_pkg::rob_entry_t [`ROB_ENTRIES-1:0] reb,
	input wire logic                                   miss_strobe,
	input wire logic                                   flushing,
	input wire logic                                   cmt_valid,
	input wire logic                                   cmt_ready,
	input wire rob_pkg::rob_commit_t                   cmt
);
	timeunit 1ns;
	timeprecision 100ps;

	// Failure tally that the testbench reads at the end of the run
	int sva_errors = 0;

	// ==============================
	// Reset and dispatch
	// ==============================

	// Straight out of reset the buffer takes dispatches and has nothing to commit
	reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> (disp_ready && !cmt_valid))
		else begin
			sva_errors++;
			$error("Buffer not idle right after reset");
		end

	// New entries only ever land on a free slot
	// A full buffer has no free slot, so nothing is allocated while full
	no_alloc_full: assert property (@(posedge clk) disable iff (!rst_n)
		alloc |-> !reb[tail].v)
		else begin
			sva_errors++;
			$error("Allocation onto a live slot");
		end

	// ==============================
	// Recovery and commit
	// ==============================

	// Flush is the cycle right after the strobe and never any other
	flush_after_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		miss_strobe |=> flushing)
		else begin
			sva_errors++;
			$error("Flush did not follow the miss strobe");
		end

	flush_needs_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		flushing |-> $past(miss_strobe))
		else begin
			sva_errors++;
			$error("Flush without a miss strobe the cycle before");
		end

	// A stalled commit keeps its record
	stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(cmt_valid && !cmt_ready) |=> (cmt_valid && $stable(cmt)))
		else begin
			sva_errors++;
			$error("Commit record changed while stalled");
		end

endmodule

bind rob_top rob_sva sva0 (
	.clk         (clk),
	.rst_n       (rst_n),
	.disp_ready  (disp_ready),
	.alloc       (alloc),
	.tail        (tail),
	.reb         (reb),
	.miss_strobe (miss_strobe),
	.flushing    (flushing),
	.cmt_valid   (cmt_valid),
	.cmt_ready   (cmt_ready),
	.cmt         (cmt)
);

`default_nettype wire

// ==== test/rob_tb.sv ====
// Reorder buffer testbench
`default_nettype none
`include "rob_params.svh"

module rob_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import rob_pkg::*;

	// Upper bound on stimulus steps
	// The watchdog allows 20 cycles for each
	localparam int MAX_STEPS = 250;

	// One instruction as it is expected to retire
	typedef struct packed {
		logic [`ROB_TAG_W-1:0] tag;
		logic [`ROB_PTR_W-1:0] slot;
		logic                  is_branch;
		logic                  done;
		logic [7:0]            result;
	} model_rec_t;

	logic                  clk;
	logic                  rst_n;
	logic                  disp_valid;
	logic                  disp_ready;
	rob_dispatch_t         disp;
	logic [`ROB_PTR_W-1:0] disp_id;
	logic                  cmpl_valid;
	rob_complete_t         cmpl;
	logic                  res_valid;
	rob_resolve_t          res;
	logic                  cmt_valid;
	logic                  cmt_ready;
	rob_commit_t           cmt;

	// Live instructions in program order, oldest at the front
	model_rec_t            model[$];
	logic [31:0]           rng_state;
	logic [`ROB_PTR_W-1:0] exp_tail;
	logic [`ROB_PTR_W-1:0] br_slot;
	logic [`ROB_TAG_W-1:0] next_tag;
	// 0 random, 1 always ready, 2 held off
	int                    ready_mode;
	int                    miss_gap;
	int                    value_errors;
	int                    other_errors;

	rob_top dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Watchdog sized from the number of stimulus steps
	initial begin
		repeat (MAX_STEPS * 20) @(posedge clk);
		$display("Watchdog expired before the tests finished");
		$display("Simulation failed");
		$finish;
	end

	// ==============================
	// Helpers
	// ==============================

	// One LCG step
	// The upper bits are used since the low ones cycle quickly
	function automatic int unsigned rand_below(input int unsigned n);
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return (rng_state >> 8) % n;
	endfunction

	// Random index of an instruction that has not completed yet, or -1
	function automatic int pick_pending(input bit only_branch);
		int cand[$];
		for (int i = 0; i < model.size(); i++)
			if (!model[i].done && (model[i].is_branch || !only_branch))
				cand.push_back(i);
		if (cand.size() == 0)
			return -1;
		return cand[rand_below(cand.size())];
	endfunction

	// Index of the pending instruction held in a slot, or -1
	function automatic int find_live(input logic [`ROB_PTR_W-1:0] slot);
		for (int i = 0; i < model.size(); i++)
			if (!model[i].done && model[i].slot == slot)
				return i;
		return -1;
	endfunction

	// Inputs are set for this cycle, so score the transfers at the next edge
	task automatic advance();
		model_rec_t rec;
		int idx;
		if (cmt_valid && cmt_ready) begin
			if (model.size() == 0) begin
				other_errors++;
				$display("A record was committed with no instruction outstanding");
			end else begin
				rec = model.pop_front();
				assert (cmt.tag == rec.tag) else begin
					value_errors++;
					$display("Error: cmt.tag is %h, expected %h", cmt.tag, rec.tag);
				end
				assert (cmt.result == rec.result) else begin
					value_errors++;
					$display("Error: cmt.result is %h, expected %h", cmt.result, rec.result);
				end
				assert (rec.done) else begin
					other_errors++;
					$display("Tag %h was committed before it completed", rec.tag);
				end
			end
		end
		idx = cmpl_valid ? find_live(cmpl.id) : -1;
		if (idx >= 0) begin
			rec = model[idx];
			rec.done = 1'b1;
			rec.result = cmpl.result;
			model[idx] = rec;
		end
		if (disp_valid && disp_ready) begin
			assert (disp_id == exp_tail) else begin
				value_errors++;
				$display("Error: disp_id is %h, expected %h", disp_id, exp_tail);
			end
			rec = '{tag: disp.tag, slot: exp_tail, is_branch: disp.is_branch,
				done: 1'b0, result: 8'h00};
			model.push_back(rec);
			exp_tail++;
			next_tag++;
		end
		miss_gap++;
		idx = res_valid ? find_live(res.id) : -1;
		if (idx >= 0) begin
			rec = model[idx];
			rec.done = 1'b1;
			model[idx] = rec;
			if (res.miss) begin
				// Everything dispatched after the branch is gone
				while (model.size() > idx + 1)
					void'(model.pop_back());
				exp_tail = res.id + 1'b1;
				miss_gap = 0;
			end
		end
		@(negedge clk);
		disp_valid = 1'b0;
		cmpl_valid = 1'b0;
		res_valid  = 1'b0;
		cmt_ready  = (ready_mode == 1) || (ready_mode == 0 && rand_below(4) != 0);
	endtask

	task automatic dispatch_one(input bit is_branch);
		bit taken;
		taken = 1'b0;
		while (!taken) begin
			disp_valid     = 1'b1;
			disp.tag       = next_tag;
			disp.is_branch = is_branch;
			taken          = disp_ready;
			advance();
		end
	endtask

	task automatic complete_random();
		int idx;
		idx = pick_pending(1'b0);
		if (idx >= 0) begin
			cmpl_valid  = 1'b1;
			cmpl.id     = model[idx].slot;
			cmpl.result = 8'(rand_below(256));
		end
	endtask

	task automatic drain();
		while (model.size() != 0) begin
			complete_random();
			advance();
		end
	endtask

	// Mixed traffic with an occasional miss once recovery has settled
	task automatic random_cycle();
		int idx;
		if (rand_below(2) == 0) begin
			disp_valid     = 1'b1;
			disp.tag       = next_tag;
			disp.is_branch = (rand_below(4) == 0);
		end
		idx = pick_pending(1'b1);
		if (miss_gap >= 3 && idx >= 0 && rand_below(6) == 0) begin
			res_valid = 1'b1;
			res.id    = model[idx].slot;
			res.miss  = 1'b1;
		end else if (rand_below(3) != 0) begin
			complete_random();
		end
		advance();
	endtask

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		rst_n = 1'b0;
		disp_valid = 1'b0;
		disp = '0;
		cmpl_valid = 1'b0;
		cmpl = '0;
		res_valid = 1'b0;
		res = '0;
		cmt_ready = 1'b0;
		rng_state = 32'h5ba9_9564;
		exp_tail = '0;
		br_slot = '0;
		next_tag = 8'h10;
		ready_mode = 1;
		miss_gap = 3;
		value_errors = 0;
		other_errors = 0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		assert (disp_ready && !cmt_valid) else begin
			other_errors++;
			$display("Buffer was not idle right after reset");
		end

		// Fill all eight slots with nothing completing and try one more
		repeat (8) dispatch_one(1'b0);
		disp_valid = 1'b1;
		assert (!disp_ready) else begin
			other_errors++;
			$display("Dispatch still ready with eight instructions in flight");
		end
		advance();
		ready_mode = 0;
		drain();

		// Miss on the fourth of six
		// Dispatch must stay shut for two cycles
		ready_mode = 1;
		repeat (3) dispatch_one(1'b0 == 1'b1);
		dispatch_one(1'b1);
		br_slot = exp_tail - 1'b1;
		repeat (2) dispatch_one(1'b0);
		res_valid = 1'b1;
		res.id    = br_slot;
		res.miss  = 1'b1;
		advance();
		repeat (2) begin
			disp_valid = 1'b1;
			disp.tag   = next_tag;
			assert (!disp_ready) else begin
				other_errors++;
				$display("Dispatch was open during branch recovery");
			end
			advance();
		end
		dispatch_one(1'b0);
		drain();

		// Commit held off while every slot completes
		ready_mode = 2;
		repeat (6) dispatch_one(1'b0);
		while (pick_pending(1'b0) >= 0) begin
			complete_random();
			advance();
		end
		repeat (8) advance();
		assert (cmt_valid) else begin
			other_errors++;
			$display("No commit was waiting while held off");
		end
		ready_mode = 1;
		drain();

		// Buffer is empty now, so both events hit dead slots
		cmpl_valid  = 1'b1;
		cmpl.id     = exp_tail + 3'd2;
		cmpl.result = 8'hee;
		res_valid   = 1'b1;
		res.id      = exp_tail + 3'd5;
		res.miss    = 1'b1;
		advance();
		repeat (3) begin
			assert (disp_ready && !cmt_valid) else begin
				other_errors++;
				$display("An event aimed at an empty slot had an effect");
			end
			advance();
		end
		repeat (3) dispatch_one(1'b0);
		drain();

		ready_mode = 0;
		repeat (150) random_cycle();
		drain();

		$display("Checks done: %0d value errors, %0d other errors, %0d assertion errors",
			value_errors, other_errors, dut0.sva0.sva_errors);
		if (value_errors == 0 && other_errors == 0 && dut0.sva0.sva_errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+include
rtl/rob_pkg.sv
rtl/rob_stomp.sv
rtl/rob_seq_alloc.sv
rtl/rob_entries.sv
rtl/rob_recovery_fsm.sv
rtl/rob_out_queue.sv
rtl/rob_top.sv
test/rob_sva.sv
test/rob_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the reorder buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module rob_tb -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
	echo "Verilator build returned an error"
	exit 1
fi

./obj_dir/Vrob_tb +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
	exit 1
fi
exit 0
